//--- include/clint_macros.svh
`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths.
`define CLINT_DATA_W 64
`define CLINT_ADDR_W 64

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clint register map, machine mode timer only.
`define CLINT_MTIMECMP_ADDR 64'h0000_0000_0200_4000
`define CLINT_MTIME_ADDR    64'h0000_0000_0200_BFF8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CLINT_TICK_DIV   16 // clocks per mtime increment.
`define CLINT_FIFO_DEPTH 2

`endif

//--- hdl/bus_pkg.sv
`include "clint_macros.svh"

package bus_pkg;

    // kind of access the memory stage offers in a cycle.
    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_kind_e;

    typedef struct packed {
        mem_kind_e                kind;
        logic [`CLINT_ADDR_W-1:0] addr;
        logic [`CLINT_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        RSP_OKAY   = 2'b00,
        RSP_DECERR = 2'b11 // same code point as the axi decode error.
    } mem_rsp_e;

    typedef struct packed {
        logic [`CLINT_DATA_W-1:0] rdata;
        mem_rsp_e                 resp;
    } mem_rsp_t;

endpackage

//--- hdl/clint_pkg.sv
`include "clint_macros.svh"

package clint_pkg;

    // register selected by the decoded address.
    typedef enum logic [1:0] {
        REG_NONE     = 2'd0,
        REG_MTIME    = 2'd1,
        REG_MTIMECMP = 2'd2
    } clint_reg_e;

    // one timer command, produced by the request builder.
    // a none select means the address hit no timer register.
    typedef struct packed {
        clint_reg_e               sel;
        logic                     write;
        logic [`CLINT_DATA_W-1:0] wdata;
    } clint_cmd_t;

endpackage

//--- hdl/clint_req_builder.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module clint_req_builder (
    input  bus_pkg::mem_req_t     mem_req_i,
    input  logic                  full_i,
    output logic                  cmd_push_o,
    output clint_pkg::clint_cmd_t cmd_o,
    output logic                  stall_o
);

    logic is_req;
    logic hit_mtime;
    logic hit_mtimecmp;

    assign is_req       = (mem_req_i.kind != bus_pkg::MEM_IDLE);
    assign hit_mtime    = (mem_req_i.addr == `CLINT_MTIME_ADDR);
    assign hit_mtimecmp = (mem_req_i.addr == `CLINT_MTIMECMP_ADDR);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode.
    always_comb begin
        if (hit_mtime) begin
            cmd_o.sel = clint_pkg::REG_MTIME;
        end else if (hit_mtimecmp) begin
            cmd_o.sel = clint_pkg::REG_MTIMECMP;
        end else begin
            cmd_o.sel = clint_pkg::REG_NONE; // answered later with a decode error.
        end
    end

    assign cmd_o.write = (mem_req_i.kind == bus_pkg::MEM_WRITE);
    assign cmd_o.wdata = mem_req_i.wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the stage holds its request while the buffer is full.
    assign cmd_push_o = is_req & ~full_i;
    assign stall_o    = full_i;

endmodule

//--- hdl/clint_fifo.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module clint_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `CLINT_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t data_i,
    output logic     full_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     pop_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               push_en;
    logic               pop_en;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q]; // head comes straight from the storage registers.

    assign push_en = push_i & ~full_o;
    assign pop_en  = pop_i & valid_o;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_en) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither.
            endcase
        end
    end

endmodule

//--- hdl/clint_timer.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module clint_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  exec_i,
    input  clint_pkg::clint_cmd_t cmd_i,
    output bus_pkg::mem_rsp_t     rsp_o,
    output logic                  mtip_o,
    output logic                  update_o
);

    localparam int TICK_W = $clog2(`CLINT_TICK_DIV);

    logic [TICK_W-1:0]        presc_q;
    logic [`CLINT_DATA_W-1:0] mtime_q;
    logic [`CLINT_DATA_W-1:0] mtimecmp_q;
    logic                     update_q;
    logic                     tick;
    logic                     wr_mtime;
    logic                     wr_mtimecmp;

    assign tick        = (presc_q == TICK_W'(`CLINT_TICK_DIV - 1));
    assign wr_mtime    = exec_i & cmd_i.write & (cmd_i.sel == clint_pkg::REG_MTIME);
    assign wr_mtimecmp = exec_i & cmd_i.write & (cmd_i.sel == clint_pkg::REG_MTIMECMP);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // prescaler and timer registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            presc_q    <= '0;
            mtime_q    <= '0;
            mtimecmp_q <= '0;
        end else begin
            presc_q <= tick ? '0 : presc_q + 1'b1;
            if (wr_mtime) begin
                mtime_q <= cmd_i.wdata; // a write wins over the tick.
            end else if (tick) begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (wr_mtimecmp) begin
                mtimecmp_q <= cmd_i.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            update_q <= 1'b0;
        end else begin
            update_q <= exec_i & cmd_i.write;
        end
    end

    // response for the command at the head, pushed by the top on execute.
    always_comb begin
        rsp_o.rdata = '0;
        rsp_o.resp  = bus_pkg::RSP_OKAY;
        case (cmd_i.sel)
            clint_pkg::REG_MTIME: begin
                if (!cmd_i.write) rsp_o.rdata = mtime_q;
            end
            clint_pkg::REG_MTIMECMP: begin
                if (!cmd_i.write) rsp_o.rdata = mtimecmp_q;
            end
            default: rsp_o.resp = bus_pkg::RSP_DECERR;
        endcase
    end

    assign mtip_o   = (mtime_q >= mtimecmp_q);
    assign update_o = update_q;

endmodule

//--- hdl/mem_clint_top.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module mem_clint_top (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::mem_req_t mem_req_i,
    output logic              stall_o,
    output logic              rsp_valid_o,
    output bus_pkg::mem_rsp_t rsp_o,
    input  logic              rsp_ready_i,
    output logic              mtip_o,
    output logic              update_o
);

    clint_pkg::clint_cmd_t cmd_in;
    clint_pkg::clint_cmd_t cmd_head;
    bus_pkg::mem_rsp_t     rsp_in;
    logic                  cmd_push;
    logic                  cmd_full;
    logic                  cmd_valid;
    logic                  rsp_full;
    logic                  exec;

    // a command runs only when its response has somewhere to go.
    assign exec = cmd_valid & ~rsp_full;

    clint_req_builder builder0 (
        .mem_req_i  (mem_req_i),
        .full_i     (cmd_full),
        .cmd_push_o (cmd_push),
        .cmd_o      (cmd_in),
        .stall_o    (stall_o)
    );

    clint_fifo #(.payload_t(clint_pkg::clint_cmd_t), .DEPTH(`CLINT_FIFO_DEPTH)) cmd_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (cmd_push),
        .data_i  (cmd_in),
        .full_o  (cmd_full),
        .valid_o (cmd_valid),
        .data_o  (cmd_head),
        .pop_i   (exec)
    );

    clint_timer timer0 (
        .clk      (clk),
        .rst      (rst),
        .exec_i   (exec),
        .cmd_i    (cmd_head),
        .rsp_o    (rsp_in),
        .mtip_o   (mtip_o),
        .update_o (update_o)
    );

    clint_fifo #(.payload_t(bus_pkg::mem_rsp_t), .DEPTH(`CLINT_FIFO_DEPTH)) rsp_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (exec),
        .data_i  (rsp_in),
        .full_o  (rsp_full),
        .valid_o (rsp_valid_o),
        .data_o  (rsp_o),
        .pop_i   (rsp_ready_i)
    );

endmodule

//--- testbench/mem_clint_assertions.sv
`timescale 1ns/100ps

module mem_clint_assertions (
    input logic              clk,
    input logic              rst,
    input bus_pkg::mem_req_t mem_req_i,
    input logic              stall_i,
    input logic              rsp_valid_i,
    input logic              rsp_ready_i,
    input bus_pkg::mem_rsp_t rsp_i,
    input logic              update_i
);

    logic       wr_accept;
    logic [3:0] wr_open_q; // writes taken at the port and not yet seen on update_o.

    assign wr_accept = (mem_req_i.kind == bus_pkg::MEM_WRITE) & ~stall_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_open_q <= '0;
        end else begin
            wr_open_q <= wr_open_q + 4'(wr_accept) - 4'(update_i);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response side handshake.
    rsp_held: assert property (@(posedge clk) disable iff (rst)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else $error("rsp_o changed or was dropped while waiting for rsp_ready_i.");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // update strobe only ever answers a write taken earlier at the port.
    upd_only_writes: assert property (@(posedge clk) disable iff (rst)
        update_i |-> wr_open_q != '0)
        else $error("update_o pulsed with no write outstanding.");

    ctrl_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({stall_i, rsp_valid_i, update_i}))
        else $error("a control output of the top level went unknown.");

endmodule

bind mem_clint_top mem_clint_assertions assert0 (
    .clk         (clk),
    .rst         (rst),
    .mem_req_i   (mem_req_i),
    .stall_i     (stall_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_i       (rsp_o),
    .update_i    (update_o)
);

//--- testbench/mem_clint_tb.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module mem_clint_tb;

    localparam int CLK_HALF      = 20;
    localparam int CYCLES_PER_OP = 40;

    typedef struct packed {
        logic [3:0]  op;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [63:0] rdata;
        logic [1:0]  resp;
    } test_op_t;

    logic              clk;
    logic              rst;
    bus_pkg::mem_req_t mem_req_i;
    logic              stall_o;
    logic              rsp_valid_o;
    bus_pkg::mem_rsp_t rsp_o;
    logic              rsp_ready_i;
    logic              mtip_o;
    logic              update_o;

    test_op_t          ops[$];
    bus_pkg::mem_rsp_t exp_q[$];
    int                cyc;
    int                push_edge;
    int                upd_due    = -1;
    int                fail_cnt   = 0;
    int                ready_mode = 0; // 0 held high, 1 lfsr gaps, 2 held low.
    int                mtime_edge = 0;
    logic [63:0]       mtime_base = '0;
    logic [31:0]       lfsr_state = 32'd92410;
    bit                loaded     = 0;

    mem_clint_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .mem_req_i   (mem_req_i),
        .stall_o     (stall_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .mtip_o      (mtip_o),
        .update_o    (update_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // index of the last edge taken out of reset.
    always @(posedge clk) begin
        if (rst) cyc <= 0;
        else cyc <= cyc + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'hD000_0001;
        return s >> 1;
    endfunction

    // mtime ticks at every edge whose index is a multiple of the divider.
    function automatic int wraps(input int first, input int last);
        if (last < first) return 0;
        return last / `CLINT_TICK_DIV - (first - 1) / `CLINT_TICK_DIV;
    endfunction

    task automatic fail_run(input string why);
        fail_cnt++;
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic take_response();
        bus_pkg::mem_rsp_t exp;
        if (exp_q.size() == 0) fail_run("a response arrived with no request pending.");
        exp = exp_q.pop_front();
        check_val("rsp_o.rdata", rsp_o.rdata, exp.rdata);
        check_val("rsp_o.resp", 64'(rsp_o.resp), 64'(exp.resp));
    endtask

    // one falling edge: drive ready, check update_o and any response taken at the next edge.
    task automatic next_cycle();
        @(negedge clk);
        mem_req_i.kind  = bus_pkg::MEM_IDLE;
        mem_req_i.addr  = '0;
        mem_req_i.wdata = '0;
        if (ready_mode == 1) begin
            lfsr_state  = lfsr_next(lfsr_state);
            rsp_ready_i = lfsr_state[0];
        end else begin
            rsp_ready_i = (ready_mode == 0);
        end
        check_val("update_o", 64'(update_o), 64'(cyc == upd_due));
        if (rsp_valid_o && rsp_ready_i) take_response();
    endtask

    task automatic issue(input bus_pkg::mem_req_t req);
        next_cycle();
        mem_req_i = req;
        while (stall_o) begin
            if (ready_mode == 2) fail_run("stall_o rose before both buffers were full.");
            next_cycle();
            mem_req_i = req;
        end
        push_edge = cyc + 1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) next_cycle();
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [63:0] f_op;
        logic [63:0] f_addr;
        logic [63:0] f_wdata;
        logic [63:0] f_rdata;
        logic [63:0] f_resp;
        test_op_t    t;
        fd = $fopen("testbench/mem_clint_tests.txt", "r");
        if (fd == 0) fail_run("cannot open testbench/mem_clint_tests.txt.");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n != 0 && $sscanf(line, "%h %h %h %h %h",
                                  f_op, f_addr, f_wdata, f_rdata, f_resp) == 5) begin
                t.op    = f_op[3:0];
                t.addr  = f_addr;
                t.wdata = f_wdata;
                t.rdata = f_rdata;
                t.resp  = f_resp[1:0];
                ops.push_back(t);
            end
        end
        $fclose(fd);
        if (ops.size() == 0) fail_run("the test file holds no operations.");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_op(input test_op_t t);
        bus_pkg::mem_req_t req;
        bus_pkg::mem_rsp_t exp;
        req.kind  = (t.op == 4'd2 || t.op == 4'd4) ? bus_pkg::MEM_WRITE : bus_pkg::MEM_READ;
        req.addr  = t.addr;
        req.wdata = t.wdata;
        exp.rdata = t.rdata;
        exp.resp  = bus_pkg::mem_rsp_e'(t.resp);
        case (t.op)
            4'd1, 4'd2: begin
                ready_mode = 1;
                issue(req);
                exp_q.push_back(exp);
                if (t.op == 4'd2) upd_due = push_edge + 1; // fifos are empty, so it runs next edge.
                drain();
            end
            4'd3: begin
                ready_mode = 0;
                issue(req);
                exp.rdata = mtime_base + 64'(wraps(mtime_edge + 1, push_edge));
                exp_q.push_back(exp);
                drain();
            end
            4'd4: begin
                ready_mode = 0;
                issue(req);
                exp_q.push_back(exp);
                mtime_base = t.wdata;
                mtime_edge = push_edge + 1;
                upd_due    = push_edge + 1;
                drain();
            end
            4'd5: begin
                next_cycle();
                check_val("mtip_o", 64'(mtip_o), t.rdata);
            end
            4'd6: begin
                ready_mode = 2;
                issue(req);
                exp_q.push_back(exp);
            end
            4'd7: begin
                next_cycle();
                check_val("stall_o", 64'(stall_o), 64'd1);
                // the two buffers hold DEPTH entries each.
                check_val("queued requests", 64'(exp_q.size()), 64'(2 * `CLINT_FIFO_DEPTH));
            end
            4'd8: begin
                ready_mode = 1;
                drain();
            end
            4'd9: repeat (int'(t.wdata)) next_cycle();
            default: fail_run($sformatf("unknown operation code %0h in the test file.", t.op));
        endcase
    endtask

    initial begin
        int limit;
        load_tests();
        limit  = (ops.size() * CYCLES_PER_OP + 8) * 2 * CLK_HALF;
        loaded = 1;
        #limit;
        fail_run("the run timed out before all tests finished.");
    end

    initial begin
        rst             = 1'b1;
        rsp_ready_i     = 1'b0;
        mem_req_i.kind  = bus_pkg::MEM_IDLE;
        mem_req_i.addr  = '0;
        mem_req_i.wdata = '0;
        wait (loaded);
        repeat (8) @(negedge clk);
        check_val("stall_o", 64'(stall_o), 64'd0);
        check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd0);
        check_val("update_o", 64'(update_o), 64'd0);
        rst = 1'b0;
        foreach (ops[i]) run_op(ops[i]);
        drain();
        repeat (4) next_cycle(); // a duplicated response would show up here.
        if (fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hdl/bus_pkg.sv
hdl/clint_pkg.sv
hdl/clint_req_builder.sv
hdl/clint_fifo.sv
hdl/clint_timer.sv
hdl/mem_clint_top.sv
testbench/mem_clint_assertions.sv
testbench/mem_clint_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = mem_clint_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/mem_clint_tests.txt
# columns: op addr wdata rdata resp, all hex; resp 0 is okay and 3 is decerr.
# op 1 read, 2 write, 3 model-checked mtime read, 4 mtime write, 5 mtip level in rdata,
# op 6 read queued with rsp_ready_i low, 7 stall expected, 8 release and drain, 9 idle wdata cycles.
5 0       0          1        0
2 2004000 123456     0        0
1 2004000 0          123456   0
5 0       0          0        0
2 2004000 abcdef00   0        0
1 2004000 0          abcdef00 0
4 200bff8 1000       0        0
9 0       25         0        0
3 200bff8 0          0        0
5 0       0          0        0
4 200bff8 fffffff000 0        0
5 0       0          1        0
9 0       14         0        0
3 200bff8 0          0        0
1 2004008 0          0        3
2 2004008 5555       0        3
2 0       7777       0        3
1 2004000 0          abcdef00 0
3 200bff8 0          0        0
6 2004000 0          abcdef00 0
6 0       0          0        3
6 2004000 0          abcdef00 0
6 2004008 0          0        3
7 0       0          0        0
8 0       0          0        0
1 2004000 0          abcdef00 0
5 0       0          1        0
